/* common/ids_macros.svh */
`ifndef IDS_MACROS_SVH
`define IDS_MACROS_SVH

`define IDS_DATA_WIDTH       64
`define IDS_CTRL_WIDTH       8

// slot count must stay a power of two, index wraps
`define IDS_NUM_SLOTS        8
`define IDS_SLOT_DEPTH       32

`define IDS_HEADER_WORDS     3   // zero-ctrl words after the first word
`define IDS_FIFO_DEPTH_BITS  2

`endif

/* common/ids_pkg.sv */
`default_nettype none

`include "ids_macros.svh"

package ids_pkg;

	typedef struct packed {
		logic [`IDS_CTRL_WIDTH-1:0] ctrl;
		logic [`IDS_DATA_WIDTH-1:0] data;
	} word_t;

	// word as written into a slot
	typedef struct packed {
		word_t word;
		logic  last;  // closing word of the packet
	} slot_word_t;

	typedef logic [$clog2(`IDS_NUM_SLOTS)-1:0] slot_idx_t;

	typedef enum logic [1:0] {
		START,
		HEADER,
		PAYLOAD
	} parse_state_e;

	typedef enum logic [1:0] {
		EMPTY,
		FILLING,
		FULL,
		DRAINING
	} slot_state_e;

endpackage

`default_nettype wire

/* logic/input_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ids_macros.svh"

module input_fifo #(
	parameter int DEPTH_BITS = `IDS_FIFO_DEPTH_BITS
) (
	input  wire logic          clk,
	input  wire logic          reset,
	input  ids_pkg::word_t     din,
	input  wire logic          wr_en,
	input  wire logic          rd_en,
	output ids_pkg::word_t     dout,
	output logic               empty,
	output logic               nearly_full
);

	localparam int DEPTH = 2 ** DEPTH_BITS;

	ids_pkg::word_t mem [DEPTH];
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS:0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en && (count != (DEPTH_BITS+1)'(DEPTH));
	assign do_rd = rd_en && !empty;

	assign dout = mem[rd_ptr];  // head visible before the read
	assign empty = (count == '0);
	assign nearly_full = (count >= (DEPTH_BITS+1)'(DEPTH - 1));

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* logic/packet_dispatcher.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ids_macros.svh"

module packet_dispatcher (
	input  wire logic                       clk,
	input  wire logic                       reset,
	input  ids_pkg::word_t                  head,
	input  wire logic                       empty,
	output logic                            rd_en,
	input  wire logic [`IDS_NUM_SLOTS-1:0]  slot_free,
	output ids_pkg::slot_word_t             slot_wdata,
	output logic [`IDS_NUM_SLOTS-1:0]       slot_we,
	output logic [31:0]                     num_packets_in
);

	localparam int HDR_CNT_W = $clog2(`IDS_HEADER_WORDS + 1);

	ids_pkg::parse_state_e state;
	ids_pkg::parse_state_e state_nxt;
	logic [HDR_CNT_W-1:0] hdr_cnt;
	logic [HDR_CNT_W-1:0] hdr_cnt_nxt;
	ids_pkg::slot_idx_t slot_idx;
	logic fwd;
	logic closing;

	always_comb begin
		state_nxt = state;
		hdr_cnt_nxt = hdr_cnt;
		rd_en = 1'b0;
		fwd = 1'b0;
		closing = 1'b0;
		if (!empty) begin
			case (state)
				ids_pkg::START: begin
					if (head.ctrl == '0) begin
						rd_en = 1'b1;  // stray word between packets, dropped
					end else if (slot_free[slot_idx]) begin
						rd_en = 1'b1;
						fwd = 1'b1;
						hdr_cnt_nxt = '0;
						state_nxt = ids_pkg::HEADER;
					end
				end
				ids_pkg::HEADER: begin
					rd_en = 1'b1;
					fwd = 1'b1;
					if (head.ctrl == '0) begin
						hdr_cnt_nxt = hdr_cnt + 1'b1;
						if (hdr_cnt_nxt == HDR_CNT_W'(`IDS_HEADER_WORDS))
							state_nxt = ids_pkg::PAYLOAD;
					end
				end
				ids_pkg::PAYLOAD: begin
					rd_en = 1'b1;
					fwd = 1'b1;
					if (head.ctrl != '0) begin
						closing = 1'b1;  // end of packet
						state_nxt = ids_pkg::START;
					end
				end
				default: state_nxt = ids_pkg::START;
			endcase
		end
	end

	assign slot_wdata.word = head;
	assign slot_wdata.last = closing;
	assign slot_we = {{(`IDS_NUM_SLOTS-1){1'b0}}, fwd} << slot_idx;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ids_pkg::START;
			hdr_cnt <= '0;
			slot_idx <= '0;
			num_packets_in <= '0;
		end else begin
			state <= state_nxt;
			hdr_cnt <= hdr_cnt_nxt;
			if (closing) begin
				slot_idx <= slot_idx + 1'b1;  // wraps
				num_packets_in <= num_packets_in + 32'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* packet_slot/packet_slot.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ids_macros.svh"

module packet_slot (
	input  wire logic           clk,
	input  wire logic           reset,
	input  ids_pkg::slot_word_t wdata,
	input  wire logic           we,
	input  wire logic           re,
	output logic                free,
	output logic                ready,
	output ids_pkg::word_t      head
);

	localparam int PTR_W = $clog2(`IDS_SLOT_DEPTH);

	ids_pkg::word_t mem [`IDS_SLOT_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] last_ptr;  // where the closing word sits
	ids_pkg::slot_state_e state;

	assign free = (state == ids_pkg::EMPTY);
	assign ready = (state == ids_pkg::FULL) || (state == ids_pkg::DRAINING);
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_ptr] <= wdata.word;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ids_pkg::EMPTY;
			wr_ptr <= '0;
			rd_ptr <= '0;
			last_ptr <= '0;
		end else begin
			case (state)
				ids_pkg::EMPTY, ids_pkg::FILLING: begin
					if (we) begin
						wr_ptr <= wr_ptr + 1'b1;
						if (wdata.last) begin
							last_ptr <= wr_ptr;
							state <= ids_pkg::FULL;
						end else begin
							state <= ids_pkg::FILLING;
						end
					end
				end
				ids_pkg::FULL, ids_pkg::DRAINING: begin
					if (re) begin
						if (rd_ptr == last_ptr) begin
							// whole packet gone, rewind for the next one
							state <= ids_pkg::EMPTY;
							wr_ptr <= '0;
							rd_ptr <= '0;
						end else begin
							rd_ptr <= rd_ptr + 1'b1;
							state <= ids_pkg::DRAINING;
						end
					end
				end
				default: state <= ids_pkg::EMPTY;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/output_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ids_macros.svh"

module output_arbiter (
	input  wire logic                       clk,
	input  wire logic                       reset,
	input  wire logic [`IDS_NUM_SLOTS-1:0]  slot_ready,
	input  ids_pkg::word_t                  slot_head [`IDS_NUM_SLOTS],
	output logic [`IDS_NUM_SLOTS-1:0]       slot_re,
	input  wire logic                       out_rdy,
	output ids_pkg::word_t                  out_word,
	output logic                            out_wr
);

	ids_pkg::slot_idx_t cur;  // next slot to drain
	logic cur_ready;
	logic was_ready;
	logic pop;

	assign cur_ready = slot_ready[cur];
	assign pop = cur_ready && out_rdy;

	assign slot_re = {{(`IDS_NUM_SLOTS-1){1'b0}}, pop} << cur;
	assign out_word = slot_head[cur];
	assign out_wr = pop;

	// ready dropping on the current slot marks its last word gone
	always_ff @(posedge clk) begin
		if (reset) begin
			cur <= '0;
			was_ready <= 1'b0;
		end else begin
			was_ready <= cur_ready;
			if (was_ready && !cur_ready)
				cur <= cur + 1'b1;  // same order as dispatch
		end
	end

endmodule

`default_nettype wire

/* logic/ids_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ids_macros.svh"

module ids_top (
	input  wire logic       clk,
	input  wire logic       reset,
	input  ids_pkg::word_t  in_word,
	input  wire logic       in_wr,
	output logic            in_rdy,
	output ids_pkg::word_t  out_word,
	output logic            out_wr,
	input  wire logic       out_rdy,
	output logic [31:0]     num_packets_in
);

	ids_pkg::word_t fifo_head;
	logic fifo_empty;
	logic fifo_rd_en;
	logic fifo_nearly_full;

	ids_pkg::slot_word_t slot_wdata;
	logic [`IDS_NUM_SLOTS-1:0] slot_we;
	logic [`IDS_NUM_SLOTS-1:0] slot_re;
	logic [`IDS_NUM_SLOTS-1:0] slot_free;
	logic [`IDS_NUM_SLOTS-1:0] slot_ready;
	ids_pkg::word_t slot_head [`IDS_NUM_SLOTS];

	assign in_rdy = !fifo_nearly_full;

	input_fifo #(
		.DEPTH_BITS (`IDS_FIFO_DEPTH_BITS)
	) in_fifo_i (
		.clk         (clk),
		.reset       (reset),
		.din         (in_word),
		.wr_en       (in_wr),
		.rd_en       (fifo_rd_en),
		.dout        (fifo_head),
		.empty       (fifo_empty),
		.nearly_full (fifo_nearly_full)
	);

	packet_dispatcher disp_i (
		.clk            (clk),
		.reset          (reset),
		.head           (fifo_head),
		.empty          (fifo_empty),
		.rd_en          (fifo_rd_en),
		.slot_free      (slot_free),
		.slot_wdata     (slot_wdata),
		.slot_we        (slot_we),
		.num_packets_in (num_packets_in)
	);

	for (genvar i = 0; i < `IDS_NUM_SLOTS; i++) begin : g_slot
		packet_slot slot_i (
			.clk   (clk),
			.reset (reset),
			.wdata (slot_wdata),  // shared, slot_we picks the target
			.we    (slot_we[i]),
			.re    (slot_re[i]),
			.free  (slot_free[i]),
			.ready (slot_ready[i]),
			.head  (slot_head[i])
		);
	end

	output_arbiter arb_i (
		.clk        (clk),
		.reset      (reset),
		.slot_ready (slot_ready),
		.slot_head  (slot_head),
		.slot_re    (slot_re),
		.out_rdy    (out_rdy),
		.out_word   (out_word),
		.out_wr     (out_wr)
	);

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // 10 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* test/ids_properties.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ids_macros.svh"

module ids_properties (
	input  wire logic                       clk,
	input  wire logic                       reset,
	input  wire logic                       out_wr,
	input  wire logic                       out_rdy,
	input  wire logic                       fifo_empty,
	input  wire logic [`IDS_NUM_SLOTS-1:0]  slot_we
);

	out_wr_needs_rdy: assert property (
		@(posedge clk) disable iff (reset) out_wr |-> out_rdy
	) else $error("out_wr high while out_rdy is low");

	// the dispatcher forwards only words it pulls from the FIFO
	no_we_when_empty: assert property (
		@(posedge clk) disable iff (reset) fifo_empty |-> (slot_we == '0)
	) else $error("slot write while the input FIFO is empty");

	quiet_after_reset: assert property (
		@(posedge clk) reset |=> !out_wr
	) else $error("out_wr high in the cycle after reset");

endmodule

bind ids_top ids_properties props_i (
	.clk        (clk),
	.reset      (reset),
	.out_wr     (out_wr),
	.out_rdy    (out_rdy),
	.fifo_empty (fifo_empty),
	.slot_we    (slot_we)
);

`default_nettype wire

/* test/ids_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ids_macros.svh"

module ids_tb;

	localparam int N_BASIC = 20;
	localparam int N_STALL = 12;
	localparam int N_SHORT = 24;
	localparam int N_LONG = 220;
	localparam int MIN_WORDS = `IDS_HEADER_WORDS + 2;
	localparam int HOT_W = $clog2(`IDS_CTRL_WIDTH);

	logic clk;
	logic reset;
	ids_pkg::word_t in_word;
	logic in_wr;
	logic in_rdy;
	ids_pkg::word_t out_word;
	logic out_wr;
	logic out_rdy;
	logic [31:0] num_packets_in;

	integer seed;
	int rdy_mode;  // 0 random, 1 held low, 2 held high
	int pkt_sent;
	int total_words;
	logic [31:0] base_count;
	string test_name;
	ids_pkg::word_t stim_q[$];
	int len_q[$];
	ids_pkg::word_t exp_q[$];

	tb_clock clk_gen_i (
		.clk   (clk),
		.reset (reset)
	);

	ids_top dut_i (
		.clk            (clk),
		.reset          (reset),
		.in_word        (in_word),
		.in_wr          (in_wr),
		.in_rdy         (in_rdy),
		.out_word       (out_word),
		.out_wr         (out_wr),
		.out_rdy        (out_rdy),
		.num_packets_in (num_packets_in)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input ids_pkg::word_t expected, input ids_pkg::word_t actual);
		if (actual !== expected)
			fail_run($sformatf("ERR %s: expected %h actual %h", test_name, expected, actual));
	endtask

	task automatic check_count(input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected)
			fail_run($sformatf("ERR %s: expected %0d actual %0d", test_name, expected, actual));
	endtask

	function automatic int random_len();
		return MIN_WORDS + int'($unsigned($random(seed)) % (`IDS_SLOT_DEPTH - MIN_WORDS + 1));
	endfunction

	task automatic make_packet(input int n_words);
		ids_pkg::word_t w;
		logic [HOT_W-1:0] hot;
		for (int i = 0; i < n_words; i++) begin
			w.data = {$random(seed), $random(seed)};
			w.ctrl = '0;
			if (i == 0) begin
				w.ctrl = '1;
			end else if (i == n_words - 1) begin
				hot = HOT_W'($unsigned($random(seed)));
				w.ctrl[hot] = 1'b1;  // one-hot closing ctrl
			end
			stim_q.push_back(w);
		end
		len_q.push_back(n_words);
	endtask

	task automatic send_packets(input int count);
		int n;
		ids_pkg::word_t w;
		for (int p = 0; p < count; p++) begin
			n = len_q.pop_front();
			for (int i = 0; i < n; i++) begin
				@(negedge clk);
				while (!in_rdy) begin
					in_wr = 1'b0;
					@(negedge clk);
				end
				w = stim_q.pop_front();
				in_word = w;
				in_wr = 1'b1;
				exp_q.push_back(w);
			end
			pkt_sent++;
		end
		@(negedge clk);
		in_wr = 1'b0;
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
	endtask

	task automatic wait_for_stall();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (in_rdy) begin
			@(negedge clk);
			cycles++;
			if (cycles > `IDS_NUM_SLOTS * `IDS_SLOT_DEPTH * 4)
				fail_run("in_rdy never fell while out_rdy was held low");
		end
	endtask

	// words are taken at the next rising edge so sample once the falling edge settles
	initial begin : out_monitor
		ids_pkg::word_t exp_w;
		out_rdy = 1'b0;
		forever begin
			@(negedge clk);
			case (rdy_mode)
				1: out_rdy = 1'b0;
				2: out_rdy = 1'b1;
				default: out_rdy = ($unsigned($random(seed)) % 4) != 0;
			endcase
			#1;
			if (!reset && out_wr) begin
				if (!out_rdy)
					fail_run("out_wr went high while out_rdy was low");
				if (exp_q.size() == 0)
					fail_run("a word left the DUT when none was expected");
				exp_w = exp_q.pop_front();
				check_word(exp_w, out_word);
			end
		end
	end

	initial begin : watchdog
		wait (total_words > 0);
		repeat (total_words * 20) @(posedge clk);
		fail_run("watchdog expired before all packets came out");
	end

	initial begin
		seed = 97;
		rdy_mode = 2;
		pkt_sent = 0;
		base_count = '0;
		test_name = "reset";
		in_word = '0;
		in_wr = 1'b0;
		for (int p = 0; p < N_BASIC + N_STALL; p++)
			make_packet(random_len());
		for (int p = 0; p < N_SHORT; p++)
			make_packet(MIN_WORDS);
		for (int p = 0; p < N_LONG; p++)
			make_packet(random_len());
		total_words = stim_q.size();
		wait (reset == 1'b0);
		@(negedge clk);

		test_name = "basic";
		send_packets(N_BASIC);
		wait_drained();
		check_count(pkt_sent, num_packets_in);

		// all slots fill and then the FIFO backs up
		test_name = "stall";
		rdy_mode = 1;
		base_count = 32'(pkt_sent);
		fork
			send_packets(N_STALL);
			begin
				wait_for_stall();
				check_count(base_count + 32'(`IDS_NUM_SLOTS), num_packets_in);
				rdy_mode = 2;
			end
		join
		wait_drained();
		check_count(pkt_sent, num_packets_in);

		test_name = "short";
		send_packets(N_SHORT);
		wait_drained();
		check_count(pkt_sent, num_packets_in);

		test_name = "throttle";
		rdy_mode = 0;
		send_packets(N_LONG);
		wait_drained();
		check_count(pkt_sent, num_packets_in);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/ids_pkg.sv
logic/input_fifo.sv
logic/packet_dispatcher.sv
packet_slot/packet_slot.sv
logic/output_arbiter.sv
logic/ids_top.sv
test/tb_clock.sv
test/ids_properties.sv
test/ids_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the packet distributor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module ids_tb -o ids_sim

./obj_dir/ids_sim | tee sim.log

if grep -q "^Simulation PASSED$" sim.log; then
	exit 0
else
	exit 1
fi
